/* Makefile */
TOP = tb_dcmi

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f list.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

/* bench/dcmi_assertions.sv */
// concurrent checks on the irq and output pulses, bound into the capture top level
module dcmi_assertions (
    input logic                       pclk,
    input logic                       rstn,
    input dcmi_frame_pkg::irq_t       irq,
    input logic                       dout_vld,
    input dcmi_cfg_pkg::capture_cfg_t cfg
);
    timeunit 1ns;
    timeprecision 1ps;

    // every pulse lasts one cycle
    a_line_start_pulse: assert property (@(posedge pclk) disable iff (!rstn)
        irq.line_start |=> !irq.line_start)
        else $error("line start irq high for two cycles");

    a_frame_start_pulse: assert property (@(posedge pclk) disable iff (!rstn)
        irq.frame_start |=> !irq.frame_start)
        else $error("frame start irq high for two cycles");

    a_frame_end_pulse: assert property (@(posedge pclk) disable iff (!rstn)
        irq.frame_end |=> !irq.frame_end)
        else $error("frame end irq high for two cycles");

    a_dout_vld_pulse: assert property (@(posedge pclk) disable iff (!rstn)
        dout_vld |=> !dout_vld)
        else $error("dout_vld high for two cycles");

    a_dout_vld_disabled: assert property (@(posedge pclk) disable iff (!rstn)
        !cfg.block_en |=> !dout_vld)
        else $error("dout_vld raised while the block is disabled");

endmodule

bind dcmi_capture_top dcmi_assertions i_assertions (
    .pclk     (pclk),
    .rstn     (rstn),
    .irq      (irq),
    .dout_vld (dout_vld),
    .cfg      (cfg)
);

/* bench/dcmi_cases.txt */
# bus crop l_start l_size p_start p_size byte_sel b_start lsel_en lsel_start
# frame_sel snapshot frames rows cols exp_line_starts  (bus 0..3 = 8,10,12,14 bit)
0 0 0 0 0 0 0 0 0 0 0 0 2 4 10 8
2 0 0 0 0 0 0 0 0 0 0 0 1 3 7 3
3 0 0 0 0 0 0 0 0 0 0 0 1 3 9 3
0 1 1 2 2 5 0 0 0 0 0 0 1 6 12 3
1 1 2 10 3 20 0 0 0 0 0 0 1 5 8 5
0 0 0 0 0 0 1 1 0 0 0 0 1 3 11 3
0 0 0 0 0 0 2 0 0 0 0 0 1 2 13 2
0 0 0 0 0 0 3 0 1 1 0 0 1 4 10 4
0 0 0 0 0 0 0 0 0 0 2 0 5 2 6 10
0 0 0 0 0 0 0 0 0 0 0 1 3 2 8 2
2 1 1 3 1 6 1 0 1 0 1 0 3 6 10 12

/* bench/tb_dcmi.sv */
// testbench for the capture top level that runs every frame listed in bench/dcmi_cases.txt
module tb_dcmi;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        int bus, crop, l_start, l_size, p_start, p_size;
        int byte_sel, b_start, lsel_en, lsel_start, frame_sel, snap;
        int frames, rows, cols, exp_lines;
    } case_t;

    logic                        pclk;
    logic                        rstn;
    dcmi_cfg_pkg::cam_pins_t     cam;
    dcmi_cfg_pkg::capture_cfg_t  cfg;
    dcmi_frame_pkg::irq_t        irq;
    logic                        dout_vld;
    dcmi_frame_pkg::pixel_word_u dout;

    case_t                       cases[$];
    dcmi_frame_pkg::pixel_word_u got_words[$];
    dcmi_frame_pkg::pixel_word_u exp_words[$];
    int ls_seen = 0;
    int fs_seen = 0;
    int fe_seen = 0;
    int errors = 0;
    int seed = 77;

    dcmi_capture_top i_dut (
        .pclk     (pclk),
        .rstn     (rstn),
        .cam      (cam),
        .cfg      (cfg),
        .irq      (irq),
        .dout_vld (dout_vld),
        .dout     (dout)
    );

    always #10 pclk = ~pclk;

    // sampled away from the active edge
    always @(negedge pclk) begin
        if (irq.line_start) ls_seen++;
        if (irq.frame_start) fs_seen++;
        if (irq.frame_end) fe_seen++;
        if (dout_vld) got_words.push_back(dout);
    end

    // --------------------------------------------------
    // expected model
    // --------------------------------------------------
    function automatic int pix_mask(input int bus);
        return (1 << (8 + 2 * bus)) - 1;  // 8, 10, 12, 14 bits
    endfunction

    function automatic bit keep_pixel(input case_t c, input int f, input int r, input int col);
        int rr;
        int cc;
        bit k;
        rr = c.crop ? r - c.l_start : r;  // window relative
        cc = c.crop ? col - c.p_start : col;
        k  = ((f % (c.frame_sel + 1)) == 0) && !(c.snap && f > 0);
        if (c.crop) begin
            k &= (r >= c.l_start) && (r < c.l_start + c.l_size);
            k &= (col >= c.p_start) && (col < c.p_start + c.p_size);
        end
        if (c.lsel_en) k &= ((rr & 1) == c.lsel_start);
        case (c.byte_sel)
            1: k &= ((cc & 1) == c.b_start);
            2: k &= ((cc & 3) == 0);
            3: k &= ((cc & 2) == 0);
            default: ;
        endcase
        return k;
    endfunction

    task automatic pack_frame(input case_t c, input int pix[$]);
        dcmi_frame_pkg::pixel_word_u w;
        int n;
        int lanes;
        w     = '0;
        n     = 0;
        lanes = (c.bus == 0) ? 4 : 2;
        foreach (pix[i]) begin
            if (c.bus == 0) w.bytes[n] = pix[i][7:0];  // little endian bytes
            else w.halves[n] = pix[i][15:0];
            n++;
            if (n == lanes) begin
                exp_words.push_back(w);
                w = '0;
                n = 0;
            end
        end
        if (n > 0) exp_words.push_back(w);  // partial word at frame end
    endtask

    function automatic dcmi_cfg_pkg::capture_cfg_t build_cfg(input case_t c);
        dcmi_cfg_pkg::capture_cfg_t k;
        k                 = '0;
        k.block_en        = 1'b1;
        k.capture_en      = 1'b1;
        k.snapshot        = c.snap[0];
        k.crop_en         = c.crop[0];
        k.bus_width       = dcmi_cfg_pkg::bus_width_e'(c.bus[1:0]);
        k.frame_sel       = c.frame_sel[1:0];
        k.byte_sel        = dcmi_cfg_pkg::byte_sel_e'(c.byte_sel[1:0]);
        k.line_sel_en     = c.lsel_en[0];
        k.line_sel_start  = c.lsel_start[0];
        k.byte_sel_start  = c.b_start[0];
        k.line_win.start  = c.l_start[13:0];
        k.line_win.size   = c.l_size[13:0];
        k.pixel_win.start = c.p_start[13:0];
        k.pixel_win.size  = c.p_size[13:0];
        return k;
    endfunction

    function automatic longint case_cycles(input case_t c);
        return 24 + c.frames * (6 + c.rows * (c.cols + 2));
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic drive(input bit vs_act, input bit hs_act, input logic [13:0] d);
        @(posedge pclk);
        cam <= '{vsync: !vs_act, hsync: !hs_act, data: d};  // syncs active low
    endtask

    // disable the block in the middle of a captured line
    task automatic abort_line();
        drive(1, 0, 0);
        drive(1, 0, 0);
        repeat (5) drive(1, 1, 14'h0a5);
        cfg.block_en <= 1'b0;
    endtask

    task automatic drive_frame(input case_t c, input int f);
        int pix[$];
        int d;
        drive(1, 0, 0);
        drive(1, 0, 0);
        for (int r = 0; r < c.rows; r++) begin
            for (int col = 0; col < c.cols; col++) begin
                d = $random(seed) & 32'h3fff;
                drive(1, 1, d[13:0]);
                if (keep_pixel(c, f, r, col)) pix.push_back(d & pix_mask(c.bus));
            end
            drive(1, 0, 0);
            drive(1, 0, 0);
        end
        repeat (4) drive(0, 0, 0);  // frame blanking
        pack_frame(c, pix);
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic compare_word(input dcmi_frame_pkg::pixel_word_u got,
                                input dcmi_frame_pkg::pixel_word_u exp, input int idx);
        if (got !== exp) begin
            $display("Mismatch at %0t: word %0d is %h, expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic compare_irq_count(input dcmi_frame_pkg::irq_t kind, input int got,
                                     input int exp);
        if (got != exp) begin
            $display("Mismatch at %0t: irq %b pulsed %0d times, expected %0d",
                     $time, kind, got, exp);
            errors++;
        end
    endtask

    task automatic run_case(input case_t c, input int idx);
        int base_w;
        int base_ls;
        int base_fs;
        int base_fe;
        int runs;
        int err0;
        err0 = errors;
        abort_line();
        @(posedge pclk);
        cfg <= '0;  // block disabled clears the DUT
        cam <= '{vsync: 1'b1, hsync: 1'b1, data: '0};
        repeat (3) @(posedge pclk);
        exp_words.delete();
        base_w  = got_words.size();
        base_ls = ls_seen;
        base_fs = fs_seen;
        base_fe = fe_seen;
        cfg <= build_cfg(c);
        repeat (4) drive(0, 0, 0);
        for (int f = 0; f < c.frames; f++) drive_frame(c, f);
        runs = c.snap ? 1 : c.frames;
        while (fe_seen - base_fe < runs) @(posedge pclk);  // wait for the last frame end
        repeat (3) @(posedge pclk);  // partial word flush
        compare_irq_count(3'b100, ls_seen - base_ls, c.exp_lines);
        compare_irq_count(3'b010, fs_seen - base_fs, runs);
        compare_irq_count(3'b001, fe_seen - base_fe, runs);
        if (got_words.size() - base_w != exp_words.size()) begin
            $display("Mismatch at %0t: case %0d produced %0d words, expected %0d",
                     $time, idx, got_words.size() - base_w, exp_words.size());
            errors++;
        end else begin
            foreach (exp_words[i]) compare_word(got_words[base_w + i], exp_words[i], i);
        end
        $display("case %0d: %0d words, %0d errors", idx, exp_words.size(), errors - err0);
    endtask

    initial begin
        int     fd;
        string  line;
        case_t  c;
        longint limit;
        pclk = 1'b0;
        rstn = 1'b0;
        cam  = '{vsync: 1'b1, hsync: 1'b1, data: '0};
        cfg  = '0;
        fd   = $fopen("bench/dcmi_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/dcmi_cases.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                c.bus, c.crop, c.l_start, c.l_size, c.p_start, c.p_size,
                                c.byte_sel, c.b_start, c.lsel_en, c.lsel_start,
                                c.frame_sel, c.snap, c.frames, c.rows, c.cols,
                                c.exp_lines) == 16)
                        cases.push_back(c);
                end
            end
            $fclose(fd);
            limit = 0;
            foreach (cases[i]) limit += case_cycles(cases[i]);
            limit = limit * 2 * 20 + 200;
            fork
                begin
                    #(limit);
                    $display("Watchdog expired before all cases completed");
                    $display("Finished with errors");
                    $finish;
                end
            join_none
            repeat (5) @(posedge pclk);
            rstn <= 1'b1;
            foreach (cases[i]) run_case(cases[i], i);
            $display("%0d cases run, %0d errors", cases.size(), errors);
            if (errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

/* capture/dcmi_crop_counter.sv */
// crop window counter for one axis, instantiated once for lines and once for pixels
module dcmi_crop_counter (
    input  logic                         pclk,
    input  logic                         rstn,
    input  logic                         enable,
    input  logic                         crop_en,
    input  dcmi_cfg_pkg::window_t        window,
    input  dcmi_frame_pkg::axis_event_t  evt,
    output dcmi_frame_pkg::axis_status_t stat
);

    logic [dcmi_cfg_pkg::COORD_W-1:0] count;
    logic [dcmi_cfg_pkg::COORD_W-1:0] start_m1, size_m1;
    logic                             active;

    assign start_m1 = window.start - 1'b1;
    assign size_m1  = window.size - 1'b1;

    // skip up to the window start, then count again from zero
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            count  <= '0;
            active <= 1'b0;
        end else if (!enable) begin
            count  <= '0;
            active <= 1'b0;
        end else if (evt.start) begin
            count  <= '0;
            active <= !crop_en || (window.start == '0);
        end else if (evt.step) begin
            if (!active && count == start_m1) begin
                count  <= '0;
                active <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign stat.active = active;
    assign stat.at_end = crop_en && active && (count == size_m1);
    assign stat.count  = count;

endmodule

/* capture/dcmi_sync_fsm.sv */
// follows external vsync/hsync framing, latches pixel data and drives the crop strobes and irqs
module dcmi_sync_fsm (
    input  logic                         pclk,
    input  logic                         rstn,
    input  dcmi_cfg_pkg::cam_pins_t      cam,
    input  dcmi_cfg_pkg::capture_cfg_t   cfg,
    input  dcmi_frame_pkg::axis_status_t axis_stat [dcmi_frame_pkg::N_AXES],
    output dcmi_frame_pkg::axis_event_t  axis_evt [dcmi_frame_pkg::N_AXES],
    output dcmi_frame_pkg::lane_t        lane,
    output dcmi_frame_pkg::irq_t         irq
);

    dcmi_frame_pkg::capture_state_e state, next_st;

    logic vsync, hsync;      // polarity corrected, active low
    logic vsync_d, hsync_d;
    logic [dcmi_cfg_pkg::PIX_W-1:0] pix_mask, pix_q;
    logic snap_done;         // snapshot frame already taken
    logic vsync_fall, vsync_rise, hsync_fall, hsync_rise;
    logic line_end_ok, pixel_end_ok;
    logic frame_go, line_go, line_step;

    // --------------------------------------------------
    // input latching
    // --------------------------------------------------
    assign vsync = cam.vsync ^ cfg.vsync_pol;
    assign hsync = cam.hsync ^ cfg.hsync_pol;

    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b0;
            hsync_d <= 1'b0;
        end else if (!cfg.block_en) begin
            vsync_d <= 1'b0;
            hsync_d <= 1'b0;
        end else begin
            vsync_d <= vsync;
            hsync_d <= hsync;
        end
    end

    always_comb begin
        case (cfg.bus_width)
            dcmi_cfg_pkg::BUS_8:  pix_mask = 14'h00ff;
            dcmi_cfg_pkg::BUS_10: pix_mask = 14'h03ff;
            dcmi_cfg_pkg::BUS_12: pix_mask = 14'h0fff;
            default:              pix_mask = 14'h3fff;
        endcase
    end

    always_ff @(posedge pclk) begin
        pix_q <= cam.data & pix_mask;
    end

    // edges between registered and live sync
    assign vsync_fall = vsync_d & ~vsync;  // frame start
    assign vsync_rise = ~vsync_d & vsync;  // frame end
    assign hsync_fall = hsync_d & ~hsync;
    assign hsync_rise = ~hsync_d & hsync;

    assign line_end_ok  = axis_stat[dcmi_frame_pkg::AXIS_LINE].at_end;
    assign pixel_end_ok = axis_stat[dcmi_frame_pkg::AXIS_PIXEL].at_end;

    // --------------------------------------------------
    // capture state machine
    // --------------------------------------------------
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            state <= dcmi_frame_pkg::IDLE;
        end else if (!cfg.block_en) begin
            state <= dcmi_frame_pkg::IDLE;
        end else begin
            state <= next_st;
        end
    end

    always_comb begin
        next_st = state;
        case (state)
            dcmi_frame_pkg::IDLE: begin
                if (cfg.capture_en && !snap_done) next_st = dcmi_frame_pkg::WAIT_FRAME_START;
            end
            dcmi_frame_pkg::WAIT_FRAME_START: begin
                if (vsync_fall) next_st = dcmi_frame_pkg::WAIT_LINE_START;
            end
            dcmi_frame_pkg::WAIT_LINE_START: begin
                if (vsync_rise) next_st = dcmi_frame_pkg::FRAME_END;
                else if (hsync_fall) next_st = dcmi_frame_pkg::LINE_RECV;
            end
            dcmi_frame_pkg::LINE_RECV, dcmi_frame_pkg::WAIT_LINE_END: begin
                if (vsync_rise) begin
                    next_st = dcmi_frame_pkg::FRAME_END;  // frame cut short
                end else if (hsync_rise) begin
                    next_st = line_end_ok ? dcmi_frame_pkg::WAIT_FRAME_END
                                          : dcmi_frame_pkg::WAIT_LINE_START;
                end else if (state == dcmi_frame_pkg::LINE_RECV && pixel_end_ok) begin
                    next_st = dcmi_frame_pkg::WAIT_LINE_END;  // rest of line is outside window
                end
            end
            dcmi_frame_pkg::WAIT_FRAME_END: begin
                if (vsync_rise) next_st = dcmi_frame_pkg::FRAME_END;
            end
            dcmi_frame_pkg::FRAME_END: begin
                if (cfg.snapshot || !cfg.capture_en) next_st = dcmi_frame_pkg::IDLE;
                else next_st = dcmi_frame_pkg::WAIT_FRAME_START;
            end
            default: next_st = dcmi_frame_pkg::IDLE;
        endcase
    end

    // held until capture is dropped, so one snapshot gives one frame
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            snap_done <= 1'b0;
        end else if (!cfg.block_en || !cfg.capture_en) begin
            snap_done <= 1'b0;
        end else if (state == dcmi_frame_pkg::FRAME_END && cfg.snapshot) begin
            snap_done <= 1'b1;
        end
    end

    // --------------------------------------------------
    // strobes and interrupts
    // --------------------------------------------------
    assign frame_go  = (state == dcmi_frame_pkg::WAIT_FRAME_START) &&
                       (next_st != dcmi_frame_pkg::WAIT_FRAME_START);
    assign line_go   = (state != dcmi_frame_pkg::LINE_RECV) &&
                       (next_st == dcmi_frame_pkg::LINE_RECV);
    assign line_step = hsync_rise && (state == dcmi_frame_pkg::LINE_RECV ||
                                      state == dcmi_frame_pkg::WAIT_LINE_END);

    assign axis_evt[dcmi_frame_pkg::AXIS_LINE].start  = frame_go;
    assign axis_evt[dcmi_frame_pkg::AXIS_LINE].step   = line_step;
    assign axis_evt[dcmi_frame_pkg::AXIS_PIXEL].start = line_go;
    assign axis_evt[dcmi_frame_pkg::AXIS_PIXEL].step  = (state == dcmi_frame_pkg::LINE_RECV);

    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            irq <= '0;
        end else if (!cfg.block_en) begin
            irq <= '0;
        end else begin
            irq.line_start  <= line_go;
            irq.frame_start <= frame_go;
            irq.frame_end   <= (state == dcmi_frame_pkg::FRAME_END);
        end
    end

    assign lane.pix         = pix_q;
    assign lane.in_line     = (state == dcmi_frame_pkg::LINE_RECV);
    assign lane.hsync_act   = ~hsync_d;  // hsync of the latched pixel
    assign lane.frame_start = frame_go;
    assign lane.frame_end   = irq.frame_end;

endmodule

/* capture/dcmi_word_packer.sv */
// applies frame, line and byte selection and packs kept pixels into 32-bit words
module dcmi_word_packer (
    input  logic                         pclk,
    input  logic                         rstn,
    input  dcmi_cfg_pkg::capture_cfg_t   cfg,
    input  dcmi_frame_pkg::lane_t        lane,
    input  dcmi_frame_pkg::axis_status_t axis_stat [dcmi_frame_pkg::N_AXES],
    output logic                         dout_vld,
    output dcmi_frame_pkg::pixel_word_u  dout
);

    logic [1:0] frame_cnt;
    logic [1:0] fill, fill_max;  // next lane of the word
    logic       frame_keep, line_keep, pix_keep, take;
    logic [dcmi_cfg_pkg::COORD_W-1:0] line_cnt, pix_cnt;
    dcmi_frame_pkg::pixel_word_u word_q, word_n;

    assign line_cnt = axis_stat[dcmi_frame_pkg::AXIS_LINE].count;
    assign pix_cnt  = axis_stat[dcmi_frame_pkg::AXIS_PIXEL].count;

    // frame selection, wraps at the programmed value
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            frame_cnt <= '0;
        end else if (!cfg.block_en) begin
            frame_cnt <= '0;
        end else if (lane.frame_end) begin
            frame_cnt <= (frame_cnt == cfg.frame_sel) ? 2'd0 : frame_cnt + 2'd1;
        end
    end
    assign frame_keep = (frame_cnt == 2'd0);

    // --------------------------------------------------
    // qualifiers
    // --------------------------------------------------
    assign line_keep = axis_stat[dcmi_frame_pkg::AXIS_LINE].active &&
                       (!cfg.line_sel_en || line_cnt[0] == cfg.line_sel_start);

    always_comb begin
        case (cfg.byte_sel)
            dcmi_cfg_pkg::BYTE_ALL:     pix_keep = 1'b1;
            dcmi_cfg_pkg::BYTE_EVERY_2: pix_keep = (pix_cnt[0] == cfg.byte_sel_start);
            dcmi_cfg_pkg::BYTE_EVERY_4: pix_keep = (pix_cnt[1:0] == 2'd0);
            default:                    pix_keep = ~pix_cnt[1];  // pairs out of four
        endcase
        pix_keep = pix_keep && axis_stat[dcmi_frame_pkg::AXIS_PIXEL].active;
    end

    assign take     = lane.in_line && lane.hsync_act && frame_keep && line_keep && pix_keep;
    assign fill_max = (cfg.bus_width == dcmi_cfg_pkg::BUS_8) ? 2'd3 : 2'd1;

    // --------------------------------------------------
    // word assembly
    // --------------------------------------------------
    always_comb begin
        word_n = (fill == 2'd0) ? '0 : word_q;  // fresh word starts zeroed
        if (cfg.bus_width == dcmi_cfg_pkg::BUS_8)
            word_n.bytes[fill] = lane.pix[7:0];
        else
            word_n.halves[fill[0]] = 16'(lane.pix);  // zero-extended
    end

    always_ff @(posedge pclk) begin
        if (take) word_q <= word_n;
    end

    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            fill     <= '0;
            dout_vld <= 1'b0;
        end else if (!cfg.block_en || lane.frame_start) begin
            fill     <= '0;
            dout_vld <= 1'b0;
        end else if (take) begin
            fill     <= (fill == fill_max) ? 2'd0 : fill + 2'd1;
            dout_vld <= (fill == fill_max);
        end else begin
            dout_vld <= lane.frame_end && (fill != 2'd0);  // flush partial word
            if (lane.frame_end) fill <= '0;
        end
    end

    assign dout = word_q;

endmodule

/* common/dcmi_cfg_pkg.sv */
// configuration types for the camera capture block, shared by the RTL and the testbench
package dcmi_cfg_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int PIX_W   = 14;  // widest camera bus
    localparam int COORD_W = 14;  // line and pixel coordinates
    localparam int WORD_W  = 32;  // packed output word

    // camera bus width
    typedef enum logic [1:0] {
        BUS_8  = 2'd0,
        BUS_10 = 2'd1,
        BUS_12 = 2'd2,
        BUS_14 = 2'd3
    } bus_width_e;

    // which pixels of a line are kept
    typedef enum logic [1:0] {
        BYTE_ALL      = 2'd0,  // every pixel
        BYTE_EVERY_2  = 2'd1,  // odd or even, by byte_sel_start
        BYTE_EVERY_4  = 2'd2,  // 0, 4, 8 ...
        BYTE_TWO_OF_4 = 2'd3   // 0-1, 4-5, 8-9 ...
    } byte_sel_e;

    // one crop axis
    typedef struct packed {
        logic [COORD_W-1:0] start;
        logic [COORD_W-1:0] size;
    } window_t;

    // all control inputs of the block
    typedef struct packed {
        logic       block_en;
        logic       capture_en;
        logic       snapshot;     // stop after one frame
        logic       crop_en;
        logic       hsync_pol;    // 1 inverts hsync
        logic       vsync_pol;    // 1 inverts vsync
        bus_width_e bus_width;
        logic [1:0] frame_sel;    // keep one frame of frame_sel + 1
        byte_sel_e  byte_sel;
        logic       line_sel_en;  // keep one line of two
        logic       line_sel_start;
        logic       byte_sel_start;
        window_t    line_win;
        window_t    pixel_win;
    } capture_cfg_t;

    // camera parallel port
    typedef struct packed {
        logic             vsync;
        logic             hsync;
        logic [PIX_W-1:0] data;
    } cam_pins_t;

endpackage

/* common/dcmi_frame_pkg.sv */
// capture state, per-axis events and status, packer lane and output word types
package dcmi_frame_pkg;

    // --------------------------------------------------
    // capture state machine
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IDLE             = 3'd0,
        WAIT_FRAME_START = 3'd1,
        WAIT_LINE_START  = 3'd2,
        LINE_RECV        = 3'd3,
        WAIT_LINE_END    = 3'd4,
        WAIT_FRAME_END   = 3'd5,
        FRAME_END        = 3'd6
    } capture_state_e;

    // crop axes
    localparam int AXIS_LINE  = 0;
    localparam int AXIS_PIXEL = 1;
    localparam int N_AXES     = 2;

    // strobes from the FSM into one crop counter
    typedef struct packed {
        logic start;  // restart the axis
        logic step;   // advance by one
    } axis_event_t;

    // state of one crop counter
    typedef struct packed {
        logic                              active;  // inside the window
        logic                              at_end;  // last coordinate of the window
        logic [dcmi_cfg_pkg::COORD_W-1:0]  count;
    } axis_status_t;

    // everything the word packer needs from the FSM
    typedef struct packed {
        logic [dcmi_cfg_pkg::PIX_W-1:0] pix;          // latched, masked by bus width
        logic                           in_line;      // FSM in LINE_RECV
        logic                           hsync_act;    // registered hsync, aligned with pix
        logic                           frame_start;  // strobe
        logic                           frame_end;    // same cycle as the irq pulse
    } lane_t;

    // interrupt pulses
    typedef struct packed {
        logic line_start;
        logic frame_start;
        logic frame_end;
    } irq_t;

    // output word, bytes in 8-bit mode, halves otherwise
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } pixel_word_u;

endpackage

/* list.f */
common/dcmi_cfg_pkg.sv
common/dcmi_frame_pkg.sv
capture/dcmi_sync_fsm.sv
capture/dcmi_crop_counter.sv
capture/dcmi_word_packer.sv
verilog/dcmi_capture_top.sv
bench/dcmi_assertions.sv
bench/tb_dcmi.sv

/* verilog/dcmi_capture_top.sv */
// top level of the camera capture block, connects the sync FSM, crop counters and packer
module dcmi_capture_top (
    input  logic                        pclk,
    input  logic                        rstn,
    input  dcmi_cfg_pkg::cam_pins_t     cam,
    input  dcmi_cfg_pkg::capture_cfg_t  cfg,
    output dcmi_frame_pkg::irq_t        irq,
    output logic                        dout_vld,
    output dcmi_frame_pkg::pixel_word_u dout
);

    dcmi_frame_pkg::axis_event_t  axis_evt  [dcmi_frame_pkg::N_AXES];
    dcmi_frame_pkg::axis_status_t axis_stat [dcmi_frame_pkg::N_AXES];
    dcmi_frame_pkg::lane_t        lane;

    dcmi_sync_fsm i_sync_fsm (
        .pclk      (pclk),
        .rstn      (rstn),
        .cam       (cam),
        .cfg       (cfg),
        .axis_stat (axis_stat),
        .axis_evt  (axis_evt),
        .lane      (lane),
        .irq       (irq)
    );

    // --------------------------------------------------
    // crop counters, index 0 lines, index 1 pixels
    // --------------------------------------------------
    for (genvar i = 0; i < dcmi_frame_pkg::N_AXES; i++) begin : g_axis
        dcmi_crop_counter i_crop (
            .pclk    (pclk),
            .rstn    (rstn),
            .enable  (cfg.block_en),
            .crop_en (cfg.crop_en),
            .window  ((i == dcmi_frame_pkg::AXIS_LINE) ? cfg.line_win : cfg.pixel_win),
            .evt     (axis_evt[i]),
            .stat    (axis_stat[i])
        );
    end

    dcmi_word_packer i_packer (
        .pclk      (pclk),
        .rstn      (rstn),
        .cfg       (cfg),
        .lane      (lane),
        .axis_stat (axis_stat),
        .dout_vld  (dout_vld),
        .dout      (dout)
    );

endmodule
